//--- hdl/obj_pkg.sv
package obj_pkg;

  // Sprites kept per scanline.
  localparam int NUM_SPRITES = 10;

  // Width of a slot index into the line buffer.
  localparam int SLOT_W = 4;

  // Dots spent in mode 2.
  localparam int MODE2_LEN = 80;

  // Sprite tiles start here in video memory.
  localparam logic [15:0] TILE_BASE = 16'h8000;

  // Visible columns per line.
  localparam int LINE_WIDTH = 160;

  // Columns covered by one sprite row.
  localparam int TILE_PIXELS = 8;

  // One line buffer entry.
  typedef struct packed {
    logic [7:0] x_pos;
    logic [7:0] y_pos;
    logic [7:0] tile_idx;
    logic       valid;
  } object_t;

  typedef enum logic [1:0] {
    PPU_MODE_0,
    PPU_MODE_1,
    PPU_MODE_2,
    PPU_MODE_3
  } ppu_mode_t;

  // Color index, zero is see-through.
  typedef logic [1:0] obj_color_t;

  localparam obj_color_t COLOR_CLEAR = 2'd0;

  // Last dot of mode 2, where every stage restarts for the new line.
  function automatic logic is_line_start(input ppu_mode_t mode,
                                         input logic [7:0] dot_counter);
    return (mode == PPU_MODE_2) && (dot_counter == 8'(MODE2_LEN - 1));
  endfunction

endpackage

//--- hdl/obj_hit_if.sv
`timescale 1ns/1ps

interface obj_hit_if import obj_pkg::*; ();

  // Level from decode: a pending sprite starts at the next column.
  logic               hit;
  object_t            sprite;
  logic [SLOT_W-1:0]  slot;
  // Pulse from execute when it accepts the sprite.
  logic               take;

  modport select_side (
    output hit,
    output sprite,
    output slot,
    input  take
  );

  modport fetch_side (
    input  hit,
    input  sprite,
    input  slot,
    output take
  );

endinterface

//--- hdl/obj_sprite_select.sv
`timescale 1ns/1ps

module obj_sprite_select import obj_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  ppu_mode_t         mode,
  input  logic [7:0]        dot_counter,
  input  logic [7:0]        pixel_x,
  input  logic              attr_we,
  input  logic [SLOT_W-1:0] attr_slot,
  input  logic [7:0]        attr_x,
  input  logic [7:0]        attr_y,
  input  logic [7:0]        attr_tile,
  input  logic              attr_valid,
  obj_hit_if.select_side    hit_bus
);

  object_t                  sprite_buf [NUM_SPRITES];
  logic [NUM_SPRITES-1:0]   pending;
  logic [NUM_SPRITES-1:0]   hit_vec;
  logic [SLOT_W-1:0]        sel_slot;
  logic [7:0]               next_x;

  // Line buffer, loaded during mode 2.
  always_ff @(posedge clk) begin
    if (attr_we && (attr_slot < SLOT_W'(NUM_SPRITES))) begin
      sprite_buf[attr_slot] <= '{
        x_pos:    attr_x,
        y_pos:    attr_y,
        tile_idx: attr_tile,
        valid:    attr_valid
      };
    end
  end

  // Pending flags, one per slot.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending <= '0;
    end else if (is_line_start(mode, dot_counter)) begin
      for (int i = 0; i < NUM_SPRITES; i++) begin
        pending[i] <= sprite_buf[i].valid;
      end
    end else if (hit_bus.take) begin
      pending[sel_slot] <= 1'b0;
    end
  end

  assign next_x = pixel_x + 8'd1;

  // Next column inside [x_pos - 8, x_pos).
  always_comb begin
    for (int i = 0; i < NUM_SPRITES; i++) begin
      hit_vec[i] = pending[i] &&
                   (next_x >= sprite_buf[i].x_pos - 8'd8) &&
                   (next_x < sprite_buf[i].x_pos);
    end
  end

  // Lowest slot wins.
  always_comb begin
    sel_slot = '0;
    for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        sel_slot = SLOT_W'(i);
      end
    end
  end

  assign hit_bus.hit    = (mode == PPU_MODE_3) && (|hit_vec);
  assign hit_bus.sprite = sprite_buf[sel_slot];
  assign hit_bus.slot   = sel_slot;

endmodule

//--- hdl/obj_tile_fetcher.sv
`timescale 1ns/1ps

module obj_tile_fetcher import obj_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  ppu_mode_t      mode,
  input  logic [7:0]     dot_counter,
  input  logic [7:0]     ly,
  obj_hit_if.fetch_side  hit_bus,
  output logic [15:0]    vram_addr,
  output logic           vram_read,
  input  logic [7:0]     vram_rdata,
  output logic           push,
  output obj_color_t     push_colors [TILE_PIXELS],
  output logic           busy
);

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_LOW,
    FETCH_HIGH,
    FETCH_PUSH
  } fetch_state_t;

  fetch_state_t state;
  logic         dot_phase;

  logic [7:0]   cur_tile;
  logic [7:0]   cur_y;
  logic [7:0]   tile_low;
  logic [7:0]   tile_high;
  logic [3:0]   row;
  logic [15:0]  row_addr;

  assign hit_bus.take = (mode == PPU_MODE_3) && (state == FETCH_IDLE) && hit_bus.hit;
  assign busy         = (state != FETCH_IDLE);

  // Two bytes per tile row, rows are 16 lines apart in y_pos space.
  always_comb begin
    row      = 4'(ly + 8'd16 - cur_y);
    row_addr = TILE_BASE + {4'd0, cur_tile, 4'd0} + {11'd0, row, 1'b0};
  end

  // Sprite fields and tile bytes.
  always_ff @(posedge clk) begin
    if (hit_bus.take) begin
      cur_tile <= hit_bus.sprite.tile_idx;
      cur_y    <= hit_bus.sprite.y_pos;
    end
    if ((mode == PPU_MODE_3) && dot_phase) begin
      if (state == FETCH_LOW) begin
        tile_low <= vram_rdata;
      end
      if (state == FETCH_HIGH) begin
        tile_high <= vram_rdata;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= FETCH_IDLE;
      dot_phase <= 1'b0;
      vram_addr <= '0;
      vram_read <= 1'b0;
      push      <= 1'b0;
    end else if (is_line_start(mode, dot_counter)) begin
      state     <= FETCH_IDLE;
      dot_phase <= 1'b0;
      vram_read <= 1'b0;
      push      <= 1'b0;
    end else if (mode == PPU_MODE_3) begin
      unique case (state)
        FETCH_IDLE: begin
          if (hit_bus.take) begin
            state     <= FETCH_LOW;
            dot_phase <= 1'b0;
          end
        end

        FETCH_LOW: begin
          if (!dot_phase) begin
            vram_addr <= row_addr;
            vram_read <= 1'b1;
            dot_phase <= 1'b1;
          end else begin
            // Low byte is captured this cycle.
            vram_read <= 1'b0;
            state     <= FETCH_HIGH;
            dot_phase <= 1'b0;
          end
        end

        FETCH_HIGH: begin
          if (!dot_phase) begin
            vram_addr <= row_addr + 16'd1;
            vram_read <= 1'b1;
            dot_phase <= 1'b1;
          end else begin
            vram_read <= 1'b0;
            push      <= 1'b1;
            state     <= FETCH_PUSH;
            dot_phase <= 1'b0;
          end
        end

        FETCH_PUSH: begin
          if (!dot_phase) begin
            push      <= 1'b0;
            dot_phase <= 1'b1;
          end else begin
            state     <= FETCH_IDLE;
            dot_phase <= 1'b0;
          end
        end

        default: begin
          state <= FETCH_IDLE;
        end
      endcase
    end
  end

  // Bit 7 is the leftmost pixel.
  always_comb begin
    for (int i = 0; i < TILE_PIXELS; i++) begin
      push_colors[i] = {tile_high[7-i], tile_low[7-i]};
    end
  end

endmodule

//--- hdl/obj_pixel_queue.sv
`timescale 1ns/1ps

module obj_pixel_queue import obj_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  ppu_mode_t   mode,
  input  logic [7:0]  dot_counter,
  input  logic        push,
  input  obj_color_t  push_colors [TILE_PIXELS],
  input  logic        stall,
  output logic        pix_valid,
  output obj_color_t  pix_color
);

  obj_color_t slots  [TILE_PIXELS];
  obj_color_t merged [TILE_PIXELS];

  // Earlier sprites keep their opaque pixels.
  always_comb begin
    for (int i = 0; i < TILE_PIXELS; i++) begin
      if (push && (slots[i] == COLOR_CLEAR)) begin
        merged[i] = push_colors[i];
      end else begin
        merged[i] = slots[i];
      end
    end
  end

  assign pix_valid = (mode == PPU_MODE_3) && !stall;
  assign pix_color = slots[0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < TILE_PIXELS; i++) begin
        slots[i] <= COLOR_CLEAR;
      end
    end else if (is_line_start(mode, dot_counter)) begin
      for (int i = 0; i < TILE_PIXELS; i++) begin
        slots[i] <= COLOR_CLEAR;
      end
    end else if (pix_valid) begin
      // Slot 0 went out, move one column left.
      for (int i = 0; i < TILE_PIXELS - 1; i++) begin
        slots[i] <= merged[i+1];
      end
      slots[TILE_PIXELS-1] <= COLOR_CLEAR;
    end else begin
      for (int i = 0; i < TILE_PIXELS; i++) begin
        slots[i] <= merged[i];
      end
    end
  end

endmodule

//--- hdl/obj_pipeline_top.sv
`timescale 1ns/1ps

module obj_pipeline_top import obj_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  ppu_mode_t         mode,
  input  logic [7:0]        dot_counter,
  input  logic [7:0]        ly,
  input  logic [7:0]        pixel_x,
  input  logic              attr_we,
  input  logic [SLOT_W-1:0] attr_slot,
  input  logic [7:0]        attr_x,
  input  logic [7:0]        attr_y,
  input  logic [7:0]        attr_tile,
  input  logic              attr_valid,
  output logic [15:0]       vram_addr,
  output logic              vram_read,
  input  logic [7:0]        vram_rdata,
  output logic              stall,
  output logic              pix_valid,
  output obj_color_t        pix_color
);

  obj_hit_if hit_bus ();

  logic       push;
  obj_color_t push_colors [TILE_PIXELS];
  logic       busy;

  // Pixel counter holds while a sprite is found or fetched.
  assign stall = hit_bus.hit | busy;

  obj_sprite_select u_select (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .dot_counter (dot_counter),
    .pixel_x     (pixel_x),
    .attr_we     (attr_we),
    .attr_slot   (attr_slot),
    .attr_x      (attr_x),
    .attr_y      (attr_y),
    .attr_tile   (attr_tile),
    .attr_valid  (attr_valid),
    .hit_bus     (hit_bus.select_side)
  );

  obj_tile_fetcher u_fetcher (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .dot_counter (dot_counter),
    .ly          (ly),
    .hit_bus     (hit_bus.fetch_side),
    .vram_addr   (vram_addr),
    .vram_read   (vram_read),
    .vram_rdata  (vram_rdata),
    .push        (push),
    .push_colors (push_colors),
    .busy        (busy)
  );

  obj_pixel_queue u_queue (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .dot_counter (dot_counter),
    .push        (push),
    .push_colors (push_colors),
    .stall       (stall),
    .pix_valid   (pix_valid),
    .pix_color   (pix_color)
  );

endmodule

//--- include/obj_ref_model.svh
`ifndef OBJ_REF_MODEL_SVH
`define OBJ_REF_MODEL_SVH

// Next value of the stimulus generator.
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1103515245 + 32'd12345;
endfunction

// Address of the low tile byte for a sprite on line ly.
function automatic logic [15:0] tile_row_addr(input object_t spr, input logic [7:0] ly);
  logic [3:0] row;
  row = 4'(ly + 8'd16 - spr.y_pos);
  return TILE_BASE + 16'(spr.tile_idx) * 16'd16 + 16'(row) * 16'd2;
endfunction

// Expected color at column col with lowest x_pos and lowest slot first.
function automatic obj_color_t expected_column_color(input object_t spr [NUM_SPRITES],
                                                     input logic [7:0] mem [65536],
                                                     input logic [7:0] ly,
                                                     input logic [7:0] col);
  obj_color_t best;
  obj_color_t c;
  logic [7:0] best_x;
  logic [15:0] addr;
  int bit_i;
  best = COLOR_CLEAR;
  best_x = 8'hff;
  for (int i = 0; i < NUM_SPRITES; i++) begin
    if (spr[i].valid && (col >= spr[i].x_pos - 8'd8) && (col < spr[i].x_pos)) begin
      addr = tile_row_addr(spr[i], ly);
      bit_i = 7 - int'(8'(col - (spr[i].x_pos - 8'd8)));
      c = {mem[addr + 16'd1][bit_i], mem[addr][bit_i]};
      if ((c != COLOR_CLEAR) && ((best == COLOR_CLEAR) || (spr[i].x_pos < best_x))) begin
        best = c;
        best_x = spr[i].x_pos;
      end
    end
  end
  return best;
endfunction

`endif

//--- verification/obj_pipeline_tb.sv
`timescale 1ns/1ps

module obj_pipeline_tb import obj_pkg::*; ();

  `include "obj_ref_model.svh"

  localparam int NUM_LINES      = 15;
  localparam int TIMEOUT_CYCLES = NUM_LINES * 400 + 100;
  localparam int LAST_PIXEL_X   = 167;
  localparam int NUM_TESTS      = 6;

  logic              clk = 1'b0;
  logic              reset;
  ppu_mode_t         mode;
  logic [7:0]        dot_counter;
  logic [7:0]        ly;
  logic [7:0]        pixel_x;
  logic              attr_we;
  logic [SLOT_W-1:0] attr_slot;
  logic [7:0]        attr_x;
  logic [7:0]        attr_y;
  logic [7:0]        attr_tile;
  logic              attr_valid;
  logic [15:0]       vram_addr;
  logic              vram_read;
  logic [7:0]        vram_rdata;
  logic              stall;
  logic              pix_valid;
  obj_color_t        pix_color;

  logic [7:0]  vram [65536];
  object_t     spr_model [NUM_SPRITES];
  logic [15:0] exp_addr_q [$];
  logic [31:0] rng_state = 32'd6;
  int          checks = 0;
  int          errors = 0;
  int          cycle_count = 0;
  int          pix_count = 0;

  always #20 clk = ~clk;

  // Video memory answers in the same cycle.
  assign vram_rdata = vram_read ? vram[vram_addr] : 8'h00;

  obj_pipeline_top DUT (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .dot_counter (dot_counter),
    .ly          (ly),
    .pixel_x     (pixel_x),
    .attr_we     (attr_we),
    .attr_slot   (attr_slot),
    .attr_x      (attr_x),
    .attr_y      (attr_y),
    .attr_tile   (attr_tile),
    .attr_valid  (attr_valid),
    .vram_addr   (vram_addr),
    .vram_read   (vram_read),
    .vram_rdata  (vram_rdata),
    .stall       (stall),
    .pix_valid   (pix_valid),
    .pix_color   (pix_color)
  );

  function automatic logic [7:0] rand_byte();
    rng_state = lcg_next(rng_state);
    return rng_state[23:16];
  endfunction

  function automatic int count_valid();
    int n;
    n = 0;
    for (int i = 0; i < NUM_SPRITES; i++) begin
      if (spr_model[i].valid) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("CHECK FAILED time %0t %s expected %0d actual %0d",
               $time, name, expected, actual);
    end
  endtask

  task automatic set_sprite(input int slot, input logic [7:0] x, input logic [7:0] y,
                            input logic [7:0] tile, input logic valid);
    spr_model[slot] = '{x_pos: x, y_pos: y, tile_idx: tile, valid: valid};
  endtask

  task automatic clear_sprites();
    for (int i = 0; i < NUM_SPRITES; i++) begin
      set_sprite(i, 8'd0, 8'd0, 8'd0, 1'b0);
    end
  endtask

  // Every row of a tile gets a slightly different byte pair.
  task automatic fill_tile(input logic [7:0] tile, input logic [7:0] low,
                           input logic [7:0] high);
    logic [15:0] base;
    base = TILE_BASE + {4'd0, tile, 4'd0};
    for (int r = 0; r < 16; r++) begin
      vram[base + 16'(2 * r)]     = low ^ 8'(r);
      vram[base + 16'(2 * r + 1)] = high ^ 8'(r << 4);
    end
  endtask

  // Reads follow x_pos order with ties broken by slot.
  task automatic build_fetch_list(input logic [7:0] line_y);
    logic        used [NUM_SPRITES];
    int          pick;
    logic [15:0] addr;
    exp_addr_q.delete();
    for (int i = 0; i < NUM_SPRITES; i++) begin
      used[i] = 1'b0;
    end
    for (int n = 0; n < NUM_SPRITES; n++) begin
      pick = -1;
      for (int i = 0; i < NUM_SPRITES; i++) begin
        if (spr_model[i].valid && !used[i] &&
            ((pick < 0) || (spr_model[i].x_pos < spr_model[pick].x_pos))) begin
          pick = i;
        end
      end
      if (pick >= 0) begin
        used[pick] = 1'b1;
        addr = tile_row_addr(spr_model[pick], line_y);
        exp_addr_q.push_back(addr);
        exp_addr_q.push_back(addr + 16'd1);
      end
    end
  endtask

  task automatic run_line(input logic [7:0] line_y, output int stall_total,
                          output int max_run);
    int run_len;
    int px;
    stall_total = 0;
    max_run     = 0;
    run_len     = 0;
    px          = 0;
    pix_count   = 0;
    build_fetch_list(line_y);
    for (int i = 0; i < NUM_SPRITES; i++) begin
      @(posedge clk);
      mode        <= PPU_MODE_0;
      dot_counter <= 8'd0;
      ly          <= line_y;
      attr_we     <= 1'b1;
      attr_slot   <= SLOT_W'(i);
      attr_x      <= spr_model[i].x_pos;
      attr_y      <= spr_model[i].y_pos;
      attr_tile   <= spr_model[i].tile_idx;
      attr_valid  <= spr_model[i].valid;
    end
    for (int d = 0; d < MODE2_LEN; d++) begin
      @(posedge clk);
      attr_we     <= 1'b0;
      mode        <= PPU_MODE_2;
      dot_counter <= 8'(d);
    end
    @(posedge clk);
    mode        <= PPU_MODE_3;
    dot_counter <= 8'(MODE2_LEN);
    pixel_x     <= 8'd0;
    while (px < LAST_PIXEL_X) begin
      @(posedge clk);
      if (stall) begin
        stall_total++;
        run_len++;
        if (run_len > max_run) begin
          max_run = run_len;
        end
      end else begin
        run_len = 0;
        px++;
        pixel_x <= 8'(px);
        if (px == LAST_PIXEL_X) begin
          mode        <= PPU_MODE_0;
          dot_counter <= 8'd0;
        end
      end
    end
    repeat (2) @(posedge clk);
    check_value("pix_valid cycles", LAST_PIXEL_X, pix_count);
    checks++;
    assert (exp_addr_q.size() == 0) else begin
      errors++;
      $display("Line %0d ended with %0d tile reads that never happened.",
               line_y, exp_addr_q.size());
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("Test %s finished with %0d errors.", name, errors - errors_before);
  endtask

  // Output checks against the reference model.
  always @(posedge clk) begin
    obj_color_t  exp_color;
    logic [15:0] exp_addr;
    if (!reset && pix_valid) begin
      checks++;
      pix_count++;
      exp_color = expected_column_color(spr_model, vram, ly, pixel_x + 8'd1);
      assert (pix_color == exp_color) else begin
        errors++;
        $display("CHECK FAILED time %0t pix_color column %0d expected %0d actual %0d",
                 $time, pixel_x + 8'd1, exp_color, pix_color);
      end
    end
    if (!reset && vram_read) begin
      checks++;
      assert (exp_addr_q.size() > 0) else begin
        errors++;
        $display("Video memory was read at time %0t although no read was due, address %h.",
                 $time, vram_addr);
      end
      if (exp_addr_q.size() > 0) begin
        exp_addr = exp_addr_q.pop_front();
        assert (vram_addr == exp_addr) else begin
          errors++;
          $display("CHECK FAILED time %0t vram_addr expected %h actual %h",
                   $time, exp_addr, vram_addr);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    int         stall_total;
    int         max_run;
    int         errors_before;
    logic [7:0] rx;
    logic [7:0] ry;
    logic [7:0] rt;
    logic [7:0] rv;
    reset       <= 1'b1;
    mode        <= PPU_MODE_0;
    dot_counter <= 8'd0;
    ly          <= 8'd0;
    pixel_x     <= 8'd0;
    attr_we     <= 1'b0;
    attr_slot   <= '0;
    attr_x      <= 8'd0;
    attr_y      <= 8'd0;
    attr_tile   <= 8'd0;
    attr_valid  <= 1'b0;
    for (int a = 0; a < 65536; a++) begin
      vram[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    end
    clear_sprites();
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    errors_before = errors;
    @(posedge clk);
    check_value("stall", 0, int'(stall));
    check_value("vram_read", 0, int'(vram_read));
    check_value("pix_valid", 0, int'(pix_valid));
    run_line(8'd0, stall_total, max_run);
    check_value("stall cycles", 0, stall_total);
    report_test("reset and empty line", errors_before);

    errors_before = errors;
    fill_tile(8'd3, 8'h3c, 8'h66);
    set_sprite(0, 8'd40, 8'd16, 8'd3, 1'b1);
    run_line(8'd20, stall_total, max_run);
    check_value("stall cycles", 7, stall_total);
    check_value("longest stall", 7, max_run);
    report_test("single sprite", errors_before);

    // Lower x_pos sits in the higher slot.
    errors_before = errors;
    clear_sprites();
    fill_tile(8'd5, 8'hff, 8'h81);
    fill_tile(8'd6, 8'ha5, 8'h0f);
    set_sprite(0, 8'd60, 8'd30, 8'd5, 1'b1);
    set_sprite(1, 8'd56, 8'd30, 8'd6, 1'b1);
    run_line(8'd33, stall_total, max_run);
    check_value("stall cycles", 14, stall_total);
    report_test("partial overlap", errors_before);

    errors_before = errors;
    clear_sprites();
    fill_tile(8'd7, 8'hc3, 8'h18);
    fill_tile(8'd8, 8'h5a, 8'hf0);
    set_sprite(2, 8'd80, 8'd40, 8'd7, 1'b1);
    set_sprite(4, 8'd80, 8'd40, 8'd8, 1'b1);
    set_sprite(3, 8'd100, 8'd40, 8'd9, 1'b0);
    run_line(8'd41, stall_total, max_run);
    check_value("stall cycles", 14, stall_total);
    check_value("longest stall", 14, max_run);
    report_test("same column and invalid slot", errors_before);

    errors_before = errors;
    clear_sprites();
    fill_tile(8'd10, 8'h96, 8'h3c);
    fill_tile(8'd11, 8'h0f, 8'hf3);
    set_sprite(0, 8'd20, 8'd50, 8'd10, 1'b1);
    set_sprite(1, 8'd120, 8'd50, 8'd11, 1'b1);
    for (int n = 0; n < 3; n++) begin
      run_line(8'(40 + 6 * n), stall_total, max_run);
      check_value("stall cycles", 14, stall_total);
    end
    report_test("several lines", errors_before);

    errors_before = errors;
    for (int a = 16'h8000; a < 16'h9000; a++) begin
      vram[a] = rand_byte();
    end
    for (int n = 0; n < 8; n++) begin
      for (int i = 0; i < NUM_SPRITES; i++) begin
        rx = rand_byte();
        ry = rand_byte();
        rt = rand_byte();
        rv = rand_byte();
        set_sprite(i, 8'(9 + int'(rx) % 160), ry, rt, rv < 8'd192);
      end
      run_line(rand_byte(), stall_total, max_run);
      check_value("stall cycles", 7 * count_valid(), stall_total);
    end
    report_test("random lines", errors_before);

    $display("Summary: %0d tests, %0d checks, %0d errors.", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
hdl/obj_pkg.sv
hdl/obj_hit_if.sv
hdl/obj_sprite_select.sv
hdl/obj_tile_fetcher.sv
hdl/obj_pixel_queue.sv
hdl/obj_pipeline_top.sv
verification/obj_pipeline_tb.sv

//--- Makefile
TOP = obj_pipeline_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

# Pass or fail comes from the printed result line.
run: compile
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
